// ==== design/hyper_bus_io.sv ====
// Pin side: bus word mux, chip select, output enables and read data reassembly
`timescale 1ns/1ns

module hyper_bus_io import xface_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  hyper_cmd_if.bus cmd,
  input  byte_t  dram_dq_in_ris,
  input  byte_t  dram_dq_in_fal,
  input  logic   dram_rwds_in_fal,
  output byte_t  dram_dq_out_ris,
  output byte_t  dram_dq_out_fal,
  output logic   dram_cs_l,
  output logic   dram_ck_en,
  output logic   dram_dq_oe_l,
  output logic   dram_rwds_oe_l,
  output logic   dram_rwds_out,
  output logic   rd_rdy,
  output dword_t rd_d,
  output logic   rd_done
);

  bus_word_t out_word;
  bus_word_t rd_hi;
  logic      rd_ping;
  logic      cs_l_nxt;
  logic      last_data;
  logic      in_ca;
  logic      is_read;

  // Word on the lanes this clock, zero while waiting
  always_comb begin
    if (cmd.phase[0]) begin
      out_word = cmd.ca.words[2];
    end else if (cmd.phase[1]) begin
      out_word = cmd.ca.words[1];
    end else if (cmd.phase[2]) begin
      out_word = cmd.ca.words[0];
    end else if (cmd.data_phase[0]) begin
      out_word = cmd.wr_data[31:16];
    end else if (cmd.data_phase[1]) begin
      out_word = cmd.wr_data[15:0];
    end else begin
      out_word = '0;
    end
  end

  assign dram_dq_out_ris = out_word[15:8];
  assign dram_dq_out_fal = out_word[7:0];
  assign dram_rwds_out   = 1'b0;  // No byte masking

  assign is_read   = (cmd.kind == mem_read);
  assign in_ca     = cmd.start | (|cmd.phase);
  assign last_data = cmd.data_phase[1] | (cmd.data_phase[0] & cmd.kind == reg_write);

  // Chip select holds low from start until the last word or read ready
  assign cs_l_nxt = ~(cmd.start | (~dram_cs_l & ~last_data & ~rd_rdy));

  // Second falling strobe completes the dword
  assign rd_done = cmd.rd_dir & dram_rwds_in_fal & rd_ping;

  // --------------------------------------------------------------------------
  // Registered pin controls
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dram_cs_l      <= 1'b1;
      dram_ck_en     <= 1'b0;
      dram_dq_oe_l   <= 1'b1;
      dram_rwds_oe_l <= 1'b1;
      rd_rdy         <= 1'b0;
      rd_ping        <= 1'b0;
    end else begin
      dram_cs_l      <= cs_l_nxt;
      dram_ck_en     <= ~cs_l_nxt;
      dram_dq_oe_l   <= cs_l_nxt | (is_read & (cmd.phase[2] | cmd.rd_dir));
      // Device owns RWDS during CA, we drive it for memory write data
      dram_rwds_oe_l <= cs_l_nxt | (cmd.kind != mem_write) | in_ca;
      rd_rdy         <= rd_done;
      if (!cmd.rd_dir) begin
        rd_ping <= 1'b0;
      end else if (dram_rwds_in_fal) begin
        rd_ping <= ~rd_ping;
      end
    end
  end

  // Read data, first word kept until the second arrives
  always_ff @(posedge clk) begin
    if (cmd.rd_dir && dram_rwds_in_fal && !rd_ping) begin
      rd_hi <= {dram_dq_in_fal, dram_dq_in_ris};
    end
    if (rd_done) begin
      rd_d <= {rd_hi, dram_dq_in_fal, dram_dq_in_ris};
    end
  end

endmodule

// ==== design/hyper_bus_pkg.sv ====
// HyperRAM protocol types: command-address word, config register, latency codes and table
package hyper_bus_pkg;

  // Command-address fields, bit 47 first on the bus
  typedef struct packed {
    logic        rw;          // 1 read, 0 write
    logic        addr_space;  // 1 register space
    logic        linear;      // 1 linear burst
    logic [28:0] row_col;
    logic [12:0] reserved;
    logic [2:0]  low_col;
  } ca_fields_t;

  // Same 48 bits as sent over the byte lanes, words[2] goes first
  typedef union packed {
    ca_fields_t       fld;
    logic [2:0][15:0] words;
  } ca_word_t;

  typedef struct packed {
    logic [7:0] lat_2x;
    logic [7:0] lat_1x;
  } latency_t;

  typedef logic [3:0] lat_code_t;

  // Configuration register 0 in the core's dword address map
  localparam logic [31:0] CFG_REG0_ADDR = 32'h0000_0800;

  // Power-on latency of the device
  localparam latency_t LAT_DEFAULT = '{lat_2x: 8'h0A, lat_1x: 8'h07};

  // Config register latency field, bits 23:20 of the written word
  localparam lat_code_t LAT_CODE_166 = 4'h1;
  localparam lat_code_t LAT_CODE_133 = 4'h0;
  localparam lat_code_t LAT_CODE_100 = 4'hF;
  localparam lat_code_t LAT_CODE_83  = 4'hE;

  // Controller wait counts for each device latency code
  function automatic latency_t lat_from_code(input lat_code_t code, input latency_t cur);
    latency_t lat;
    case (code)
      LAT_CODE_166: lat = LAT_DEFAULT;
      LAT_CODE_133: lat = '{lat_2x: 8'h08, lat_1x: 8'h06};
      LAT_CODE_100: lat = '{lat_2x: 8'h06, lat_1x: 8'h05};
      LAT_CODE_83:  lat = '{lat_2x: 8'h04, lat_1x: 8'h04};
      default:      lat = cur;  // Unknown code, keep what we have
    endcase
    return lat;
  endfunction

endpackage

// ==== design/hyper_cmd_if.sv ====
// Captured-request interface between request capture, sequencer and pin logic
`timescale 1ns/1ns

interface hyper_cmd_if import xface_pkg::*, hyper_bus_pkg::*; ();

  // From request capture
  logic      start;
  req_kind_t kind;
  ca_word_t  ca;
  dword_t    wr_data;
  latency_t  latency;

  // From sequencer
  logic [2:0] phase;       // One-hot CA word select
  logic [1:0] data_phase;  // Bit 0 high half, bit 1 low half
  logic       rd_dir;
  logic       busy;
  logic       lat_2x_hit;

  modport req (output start, kind, ca, wr_data, latency, input busy);
  modport seq (input start, kind, latency,
               output phase, data_phase, rd_dir, busy, lat_2x_hit);
  modport bus (input start, kind, ca, wr_data, phase, data_phase, rd_dir);

endinterface

// ==== design/hyper_request.sv ====
// Request capture, command-address packing and latency register
`timescale 1ns/1ns

module hyper_request import xface_pkg::*, hyper_bus_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   rd_req,
  input  logic   wr_req,
  input  logic   mem_or_reg,
  input  dword_t addr,
  input  dword_t wr_d,
  hyper_cmd_if.req cmd
);

  logic      accept;
  req_kind_t kind_nxt;
  ca_word_t  ca_nxt;

  // Requests while busy are dropped
  assign accept = (rd_req | wr_req) & ~cmd.busy;

  // Register reads are not supported, so any read is a memory read
  always_comb begin
    if (rd_req) begin
      kind_nxt = mem_read;
    end else if (mem_or_reg) begin
      kind_nxt = reg_write;
    end else begin
      kind_nxt = mem_write;
    end
  end

  // ------------------------------------------------------------------------
  // CA word packing
  // ------------------------------------------------------------------------
  always_comb begin
    ca_nxt = '0;
    ca_nxt.fld.rw         = rd_req;
    ca_nxt.fld.addr_space = (kind_nxt == reg_write);
    ca_nxt.fld.linear     = 1'b1;
    if (kind_nxt == reg_write) begin
      // Registers are 16 bit wide, keep the word bit
      ca_nxt.fld.row_col = addr[31:3];
      ca_nxt.fld.low_col = addr[2:0];
    end else begin
      // Dword address, always the even half-word
      ca_nxt.fld.row_col = addr[30:2];
      ca_nxt.fld.low_col = {addr[1:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.start   <= 1'b0;
      cmd.latency <= LAT_DEFAULT;
    end else begin
      cmd.start <= accept;
      // Track the device latency from config register 0 writes
      if (accept && kind_nxt == reg_write && addr == CFG_REG0_ADDR) begin
        cmd.latency <= lat_from_code(wr_d[23:20], cmd.latency);
      end
    end
  end

  // Request payload, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.kind    <= kind_nxt;
      cmd.ca      <= ca_nxt;
      cmd.wr_data <= wr_d;
    end
  end

endmodule

// ==== design/hyper_sequencer.sv ====
// Access sequencer: CA phase shifter, latency wait counter, busy and bus direction
`timescale 1ns/1ns

module hyper_sequencer import xface_pkg::*; #(
  parameter int WAIT_W = 6
) (
  input  logic clk,
  input  logic reset,
  input  logic dram_rwds_in_ris,
  input  logic rd_done,
  hyper_cmd_if.seq cmd
);

  logic              busy_q;
  logic [WAIT_W-1:0] wait_cnt;
  logic              wr_end;
  logic              is_mem_wr;
  logic              is_reg_wr;
  logic              wait_done;

  assign is_mem_wr = (cmd.kind == mem_write);
  assign is_reg_wr = (cmd.kind == reg_write);

  // Last wait cycle, data goes out next
  assign wait_done = (wait_cnt == WAIT_W'(1));

  // Busy rises with start so a back-to-back request is already blocked
  assign cmd.busy = cmd.start | busy_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.phase      <= '0;
      cmd.data_phase <= '0;
      cmd.rd_dir     <= 1'b0;
      cmd.lat_2x_hit <= 1'b0;
      wait_cnt       <= '0;
      wr_end         <= 1'b0;
      busy_q         <= 1'b0;
    end else begin
      // Three CA words, one per clock
      cmd.phase      <= {cmd.phase[1:0], cmd.start};
      cmd.lat_2x_hit <= 1'b0;

      // ----------------------------------------------------------------------
      // Latency wait
      // ----------------------------------------------------------------------
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      // Device holds RWDS high on the last CA cycle when it needs 2x
      if (cmd.phase[2] && is_mem_wr) begin
        if (dram_rwds_in_ris) begin
          wait_cnt       <= cmd.latency.lat_2x[WAIT_W-1:0];
          cmd.lat_2x_hit <= 1'b1;
        end else begin
          wait_cnt <= cmd.latency.lat_1x[WAIT_W-1:0];
        end
      end

      // Register writes have no latency, data right after CA
      cmd.data_phase[0] <= (cmd.phase[2] & is_reg_wr) | wait_done;
      cmd.data_phase[1] <= cmd.data_phase[0] & is_mem_wr;
      wr_end            <= cmd.data_phase[1] | (cmd.data_phase[0] & is_reg_wr);

      // Turn the bus around after CA, back when the dword is in
      if (cmd.phase[2] && cmd.kind == mem_read) begin
        cmd.rd_dir <= 1'b1;
      end else if (rd_done) begin
        cmd.rd_dir <= 1'b0;
      end

      // Writes end one clock after chip select rises
      if (cmd.start) begin
        busy_q <= 1'b1;
      end else if (wr_end || rd_done) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== design/hyper_xface.sv ====
// HyperRAM dword controller top: request capture, sequencer and pin logic
`timescale 1ns/1ns

module hyper_xface import xface_pkg::*; #(
  parameter int WAIT_W = 6
) (
  input  logic   clk,
  input  logic   reset,
  // User side
  input  logic   rd_req,
  input  logic   wr_req,
  input  logic   mem_or_reg,
  input  dword_t addr,
  input  dword_t wr_d,
  output dword_t rd_d,
  output logic   rd_rdy,
  output logic   busy,
  output logic   lat_2x,
  // DRAM side, split DDR lanes
  output logic   dram_rst_l,
  output logic   dram_ck_en,
  output logic   dram_cs_l,
  input  byte_t  dram_dq_in_ris,
  input  byte_t  dram_dq_in_fal,
  output byte_t  dram_dq_out_ris,
  output byte_t  dram_dq_out_fal,
  output logic   dram_dq_oe_l,
  input  logic   dram_rwds_in_ris,
  input  logic   dram_rwds_in_fal,
  output logic   dram_rwds_out,
  output logic   dram_rwds_oe_l
);

  logic rd_done;

  hyper_cmd_if cmd ();

  assign dram_rst_l = ~reset;
  assign busy       = cmd.busy;
  assign lat_2x     = cmd.lat_2x_hit;

  hyper_request u_request (
    .clk, .reset, .rd_req, .wr_req, .mem_or_reg, .addr, .wr_d,
    .cmd (cmd.req)
  );

  hyper_sequencer #(.WAIT_W(WAIT_W)) u_sequencer (
    .clk, .reset, .dram_rwds_in_ris, .rd_done,
    .cmd (cmd.seq)
  );

  hyper_bus_io u_bus_io (
    .clk, .reset, .cmd (cmd.bus),
    .dram_dq_in_ris, .dram_dq_in_fal, .dram_rwds_in_fal,
    .dram_dq_out_ris, .dram_dq_out_fal, .dram_cs_l, .dram_ck_en,
    .dram_dq_oe_l, .dram_rwds_oe_l, .dram_rwds_out, .rd_rdy, .rd_d, .rd_done
  );

endmodule

// ==== design/xface_pkg.sv ====
// Core-side types: dword, byte and bus word, request kind
package xface_pkg;

  // User data word
  typedef logic [31:0] dword_t;

  // One DDR lane half
  typedef logic [7:0] byte_t;

  // Word moved per DRAM clock, rising byte on top
  typedef logic [15:0] bus_word_t;

  // What the accepted request turned into
  typedef enum logic [1:0] {
    mem_write = 2'd0,
    mem_read  = 2'd1,
    reg_write = 2'd2
  } req_kind_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the HyperRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_hyper_xface -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_hyper_xface)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// ==== src.f ====
design/xface_pkg.sv
design/hyper_bus_pkg.sv
design/hyper_cmd_if.sv
design/hyper_request.sv
design/hyper_sequencer.sv
design/hyper_bus_io.sv
design/hyper_xface.sv
testbench/hyper_checker.sv
testbench/tb_hyper_xface.sv

// ==== testbench/hyper_checker.sv ====
// Testbench checker: reset state, pin controls, CA fields, cs-low width, read data, test report
`timescale 1ns/1ns

module hyper_checker import xface_pkg::*, hyper_bus_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // DUT pins under watch
  input  logic      dram_rst_l,
  input  logic      dram_ck_en,
  input  logic      dram_cs_l,
  input  logic      dram_dq_oe_l,
  input  byte_t     dram_dq_out_ris,
  input  byte_t     dram_dq_out_fal,
  input  logic      dram_rwds_out,
  input  logic      dram_rwds_oe_l,
  input  logic      busy,
  input  logic      rd_rdy,
  input  logic      lat_2x,
  input  dword_t    rd_d,
  // Current table row and what the responder stored
  input  logic      row_done,
  input  req_kind_t exp_kind,
  input  dword_t    exp_addr,
  input  dword_t    exp_wr_d,
  input  logic      exp_2x,
  input  dword_t    exp_value,
  input  dword_t    resp_word,
  output int        tests_run,
  output int        tests_failed,
  output int        check_errors
);

  int       cs_cnt;
  int       cs_width;
  int       lat_2x_cnt;
  int       rd_rdy_cnt;
  int       row_errs;
  dword_t   rd_seen;
  ca_word_t ca_seen;
  logic     oe_after_ca;
  logic     rwds_oe_last;
  logic     reset_q = 1'b1;

  task automatic check_val(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED test %0d %s: got 0x%h expected 0x%h", tests_run, name, got, exp);
      row_errs++;
      check_errors++;
    end
  endtask

  task automatic finish_test(input string label);
    if (row_errs == 0) begin
      $display("test %0d %s: ok", tests_run, label);
    end else begin
      $display("test %0d %s: %0d checks failed", tests_run, label, row_errs);
      tests_failed++;
    end
    tests_run++;
    row_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // One finished table row
  // --------------------------------------------------------------------------
  task automatic score_row();
    ca_word_t ca_exp;
    // CA word as the protocol lays it out with bit 47 first
    if (exp_kind == reg_write) begin
      ca_exp = {1'b0, 1'b1, 1'b1, exp_addr[31:3], 13'h0, exp_addr[2:0]};
    end else begin
      ca_exp = {exp_kind == mem_read, 1'b0, 1'b1, exp_addr[30:2], 13'h0, exp_addr[1:0], 1'b0};
    end
    check_val("ca.rw", 32'(ca_seen.fld.rw), 32'(ca_exp.fld.rw));
    check_val("ca.addr_space", 32'(ca_seen.fld.addr_space), 32'(ca_exp.fld.addr_space));
    check_val("ca.linear", 32'(ca_seen.fld.linear), 32'(ca_exp.fld.linear));
    check_val("ca.row_col", 32'(ca_seen.fld.row_col), 32'(ca_exp.fld.row_col));
    check_val("ca.low_col", 32'(ca_seen.fld.low_col), 32'(ca_exp.fld.low_col));
    // Bus released right after CA only on reads
    check_val("dram_dq_oe_l", 32'(oe_after_ca), 32'(exp_kind == mem_read));
    // RWDS driven by the controller only for memory write data
    check_val("dram_rwds_oe_l", 32'(rwds_oe_last), 32'(exp_kind != mem_write));
    if (exp_kind == mem_read) begin
      check_val("rd_d", rd_seen, exp_value);
      check_val("rd_rdy", rd_rdy_cnt, 1);
      check_val("lat_2x", lat_2x_cnt, 0);
    end else begin
      check_val("dram_cs_l width", cs_width, exp_value);
      check_val("rd_rdy", rd_rdy_cnt, 0);
      check_val("lat_2x", lat_2x_cnt, 32'(exp_2x && exp_kind == mem_write));
      if (exp_kind == mem_write) begin
        check_val("stored word", resp_word, exp_wr_d);
      end
    end
    finish_test($sformatf("%s at 0x%h", exp_kind.name(), exp_addr));
    cs_width   = 0;
    lat_2x_cnt = 0;
    rd_rdy_cnt = 0;
    rd_seen    = '0;
  endtask

  // Sample mid-cycle where all DUT outputs are settled
  always @(negedge clk) begin
    if (reset) begin
      check_val("dram_rst_l", 32'(dram_rst_l), 0);
    end
    if (reset_q && !reset) begin
      check_val("busy", 32'(busy), 0);
      check_val("rd_rdy", 32'(rd_rdy), 0);
      check_val("lat_2x", 32'(lat_2x), 0);
      check_val("dram_cs_l", 32'(dram_cs_l), 1);
      check_val("dram_dq_oe_l", 32'(dram_dq_oe_l), 1);
      check_val("dram_rwds_oe_l", 32'(dram_rwds_oe_l), 1);
      check_val("dram_ck_en", 32'(dram_ck_en), 0);
      check_val("dram_rst_l", 32'(dram_rst_l), 1);
      finish_test("reset state");
    end
    reset_q = reset;
    if (!reset) begin
      // Write data is never masked
      check_val("dram_rwds_out", 32'(dram_rwds_out), 0);
      // Device clock runs only while selected
      check_val("dram_ck_en", 32'(dram_ck_en), 32'(!dram_cs_l));
      if (!dram_cs_l) begin
        // First three cs-low cycles carry the CA word
        case (cs_cnt)
          0:       ca_seen.words[2] = {dram_dq_out_ris, dram_dq_out_fal};
          1:       ca_seen.words[1] = {dram_dq_out_ris, dram_dq_out_fal};
          2:       ca_seen.words[0] = {dram_dq_out_ris, dram_dq_out_fal};
          3:       oe_after_ca = dram_dq_oe_l;
          default: ;
        endcase
        rwds_oe_last = dram_rwds_oe_l;
        cs_cnt++;
      end else if (cs_cnt != 0) begin
        cs_width = cs_cnt;
        cs_cnt   = 0;
      end
      if (lat_2x) begin
        lat_2x_cnt++;
      end
      if (rd_rdy) begin
        rd_rdy_cnt++;
        rd_seen = rd_d;
      end
      if (row_done) begin
        score_row();
      end
    end
  end

endmodule

// ==== testbench/tb_hyper_xface.sv ====
// Testbench top: clock, reset, stimulus table, LFSR, HyperRAM responder and watchdog
`timescale 1ns/1ns

module tb_hyper_xface import xface_pkg::*, hyper_bus_pkg::*;;

  typedef struct packed {
    req_kind_t kind;
    dword_t    addr;
    dword_t    wr_d;
    logic      force_2x;
    dword_t    exp_val;   // cs-low width for writes, rd_d for reads
  } row_t;

  localparam int N_ROWS = 9;

  // Widths are 5 + L for memory writes and 4 for register writes
  localparam row_t ROWS [N_ROWS] = '{
    '{mem_write, 32'h0000_0010, 32'h1234_5678, 1'b0, 32'd12},  // lat_1x 7
    '{mem_write, 32'h0000_0024, 32'hA5C3_0F96, 1'b1, 32'd15},  // lat_2x 10
    '{mem_read,  32'h0000_0010, 32'h0000_0000, 1'b0, 32'h1234_5678},
    '{reg_write, 32'h0000_0800, 32'h8FE0_0000, 1'b0, 32'd4},   // Code E
    '{mem_write, 32'h0000_0038, 32'h0BAD_F00D, 1'b0, 32'd9},   // lat_1x 4 now
    '{mem_read,  32'h0000_0024, 32'h0000_0000, 1'b0, 32'hA5C3_0F96},
    '{mem_read,  32'h0000_0038, 32'h0000_0000, 1'b0, 32'h0BAD_F00D},
    '{mem_write, 32'h0000_0010, 32'hCAFE_BEEF, 1'b1, 32'd9},   // lat_2x 4
    '{mem_read,  32'h0000_0010, 32'h0000_0000, 1'b0, 32'hCAFE_BEEF}
  };

  logic   clk = 1'b0;
  logic   reset;
  logic   rd_req, wr_req, mem_or_reg;
  dword_t addr, wr_d, rd_d;
  logic   rd_rdy, busy, lat_2x;
  logic   dram_rst_l, dram_ck_en, dram_cs_l;
  byte_t  dram_dq_in_ris, dram_dq_in_fal, dram_dq_out_ris, dram_dq_out_fal;
  logic   dram_dq_oe_l, dram_rwds_in_ris, dram_rwds_in_fal;
  logic   dram_rwds_out, dram_rwds_oe_l;

  row_t        row;
  logic        row_done;
  logic        force_2x;
  dword_t      resp_word;
  dword_t      store [16];
  logic [31:0] lfsr = 32'd90898;
  int          tests_run, tests_failed, check_errors;

  always #50 clk = ~clk;

  hyper_xface #(.WAIT_W(6)) hyper_xface_i (
    .clk, .reset, .rd_req, .wr_req, .mem_or_reg, .addr, .wr_d, .rd_d, .rd_rdy,
    .busy, .lat_2x, .dram_rst_l, .dram_ck_en, .dram_cs_l, .dram_dq_in_ris,
    .dram_dq_in_fal, .dram_dq_out_ris, .dram_dq_out_fal, .dram_dq_oe_l,
    .dram_rwds_in_ris, .dram_rwds_in_fal, .dram_rwds_out, .dram_rwds_oe_l
  );

  hyper_checker checker_i (
    .clk, .reset, .dram_rst_l, .dram_ck_en, .dram_cs_l, .dram_dq_oe_l,
    .dram_dq_out_ris, .dram_dq_out_fal, .dram_rwds_out, .dram_rwds_oe_l,
    .busy, .rd_rdy, .lat_2x, .rd_d, .row_done, .exp_kind(row.kind), .exp_addr(row.addr),
    .exp_wr_d(row.wr_d), .exp_2x(row.force_2x), .exp_value(row.exp_val), .resp_word,
    .tests_run, .tests_failed, .check_errors
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------------------------------
  // HyperRAM responder
  // --------------------------------------------------------------------------
  initial begin : responder
    ca_word_t  ca;
    bus_word_t prev;
    bus_word_t last;
    dword_t    word;
    int        delay;
    dram_dq_in_ris   = '0;
    dram_dq_in_fal   = '0;
    dram_rwds_in_ris = 1'b0;
    dram_rwds_in_fal = 1'b0;
    resp_word        = '0;
    @(negedge reset);
    forever begin
      while (dram_cs_l) begin
        next_cycle();
      end
      // RWDS high through CA asks for 2x latency
      dram_rwds_in_ris = force_2x;
      ca.words[2] = {dram_dq_out_ris, dram_dq_out_fal};
      next_cycle();
      ca.words[1] = {dram_dq_out_ris, dram_dq_out_fal};
      next_cycle();
      ca.words[0] = {dram_dq_out_ris, dram_dq_out_fal};
      next_cycle();
      dram_rwds_in_ris = 1'b0;
      if (!ca.fld.rw) begin
        prev = '0;
        last = '0;
        while (!dram_cs_l) begin
          prev = last;
          last = {dram_dq_out_ris, dram_dq_out_fal};
          next_cycle();
        end
        if (!ca.fld.addr_space) begin
          store[ca.fld.row_col[3:0]] = {prev, last};
          resp_word = {prev, last};
        end
      end else begin
        // Random initial latency of 2 to 9 cycles
        delay = 2;
        for (int b = 0; b < 3; b++) begin
          lfsr  = lfsr_next(lfsr);
          delay = delay + (int'(lfsr[0]) << b);
        end
        repeat (delay) next_cycle();
        // Read lanes land in rd_d falling byte first
        word = store[ca.fld.row_col[3:0]];
        dram_rwds_in_fal = 1'b1;
        dram_dq_in_fal   = word[31:24];
        dram_dq_in_ris   = word[23:16];
        next_cycle();
        dram_dq_in_fal   = word[15:8];
        dram_dq_in_ris   = word[7:0];
        next_cycle();
        dram_rwds_in_fal = 1'b0;
        dram_dq_in_fal   = '0;
        dram_dq_in_ris   = '0;
        while (!dram_cs_l) begin
          next_cycle();
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    rd_req     = 1'b0;
    wr_req     = 1'b0;
    mem_or_reg = 1'b0;
    addr       = '0;
    wr_d       = '0;
    row        = '0;
    row_done   = 1'b0;
    force_2x   = 1'b0;
    reset      = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < N_ROWS; i++) begin
      row      = ROWS[i];
      force_2x = ROWS[i].force_2x;
      next_cycle();
      addr       = row.addr;
      wr_d       = row.wr_d;
      mem_or_reg = (row.kind == reg_write);
      rd_req     = (row.kind == mem_read);
      wr_req     = (row.kind != mem_read);
      next_cycle();
      rd_req = 1'b0;
      wr_req = 1'b0;
      while (busy) begin
        next_cycle();
      end
      // Let cs rise after a read before the row is scored
      repeat (2) next_cycle();
      row_done = 1'b1;
      next_cycle();
      row_done = 1'b0;
    end
    repeat (2) next_cycle();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             check_errors);
    if (tests_failed == 0 && check_errors == 0 && tests_run == N_ROWS + 1) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (16 + N_ROWS * 40) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", 16 + N_ROWS * 40);
    $display("Test failed");
    $finish;
  end

endmodule
